/* poly_data_pkg.sv */
`default_nettype none

// Widths and stage counts of the polynomial datapath
package poly_data_pkg;

    localparam int W        = 16;

    // Power stages produce x^2 up to x^(N_STAGES + 1)
    localparam int N_STAGES = 4;

    // One coefficient per power from x^0 to x^(N_STAGES + 1)
    localparam int N_COEFS  = N_STAGES + 2;

    // Samples, powers, products and sums share one width and wrap modulo 2^W
    typedef logic [W - 1:0] data_t;

    typedef logic [W - 1:0] coef_t;

    typedef logic [$clog2(N_COEFS) - 1:0] coef_addr_t;

endpackage

`default_nettype wire

/* poly_ctrl_pkg.sv */
`default_nettype none

// Handshake control definitions
package poly_ctrl_pkg;

    // Receiver: idle, sample just captured, waiting for in_req to drop
    typedef enum logic [1:0]
    {
        RX_IDLE,
        RX_ACK,
        RX_WAIT_LOW
    } rx_state_t;

    // Sender: idle, result offered, waiting for out_ack to drop
    typedef enum logic [1:0]
    {
        TX_IDLE,
        TX_REQ,
        TX_WAIT_LOW
    } tx_state_t;

    // Cycles from in_ack rising to out_req rising with the output idle
    localparam int LATENCY = poly_data_pkg::N_STAGES + 3;

endpackage

`default_nettype wire

/* sample_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_rx
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_req,
    output logic                 in_ack,
    input  poly_data_pkg::data_t in_data,
    input  logic                 pipe_en,
    output logic                 sample_vld,
    output poly_data_pkg::data_t sample_x
);

    import poly_ctrl_pkg::*;

    rx_state_t state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= RX_IDLE;
        end
        else
        begin
            case (state)
                RX_IDLE:
                    if (pipe_en && in_req)
                        state <= RX_ACK;
                // The sample stays offered until the pipeline takes it
                RX_ACK:
                    if (pipe_en)
                        state <= RX_WAIT_LOW;
                RX_WAIT_LOW:
                    if (!in_req)
                        state <= RX_IDLE;
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RX_IDLE && pipe_en && in_req)
            sample_x <= in_data;
    end

    // in_ack stays up from the capture until in_req has dropped
    assign in_ack     = (state != RX_IDLE);
    assign sample_vld = (state == RX_ACK);

endmodule

`default_nettype wire

/* pow_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module pow_pipe
(
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                pipe_en,
    input  logic                                                sample_vld,
    input  poly_data_pkg::data_t                                sample_x,
    output poly_data_pkg::data_t                                pow_x1,
    output logic                 [poly_data_pkg::N_STAGES:0]     pow_vld,
    output poly_data_pkg::data_t [poly_data_pkg::N_STAGES - 1:0] pow_bus
);

    import poly_data_pkg::*;

    // Delay line of the sample, so stage k multiplies by x from the same sample
    data_t              x_reg   [1:N_STAGES];
    data_t              pw      [2:N_STAGES + 1];
    logic  [1:N_STAGES + 1] vld_reg;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld_reg <= '0;
        end
        else if (pipe_en)
        begin
            vld_reg[1] <= sample_vld;
            for (int i = 1; i <= N_STAGES; i++)
                vld_reg[i + 1] <= vld_reg[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe_en)
        begin
            x_reg[1] <= sample_x;
            for (int i = 1; i <= N_STAGES - 1; i++)
                x_reg[i + 1] <= x_reg[i];

            pw[2] <= x_reg[1] * x_reg[1];
            for (int i = 2; i <= N_STAGES; i++)
                pw[i + 1] <= pw[i] * x_reg[i];
        end
    end

    assign pow_x1 = x_reg[1];

    // Bit 0 of pow_vld belongs to x itself, bit k to power k + 1
    always_comb
    begin
        for (int k = 1; k <= N_STAGES + 1; k++)
            pow_vld[k - 1] = vld_reg[k];
        for (int k = 2; k <= N_STAGES + 1; k++)
            pow_bus[k - 2] = pw[k];
    end

endmodule

`default_nettype wire

/* coef_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module coef_pipe
(
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                pipe_en,
    input  logic                                                coef_we,
    input  poly_data_pkg::coef_addr_t                           coef_addr,
    input  poly_data_pkg::coef_t                                coef_wdata,
    input  logic                                                sample_vld,
    output poly_data_pkg::coef_t                                coef_c0,
    output poly_data_pkg::coef_t                                coef_c1,
    output poly_data_pkg::coef_t [poly_data_pkg::N_STAGES - 1:0] coef_stage
);

    import poly_data_pkg::*;

    coef_t bank      [N_COEFS];
    coef_t held_bank [N_COEFS];
    logic  held;

    // Row s is the snapshot after enabled edge Es; only c_s and above still travel
    coef_t snap      [1:N_STAGES + 1][N_COEFS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < N_COEFS; i++)
                bank[i] <= '0;
        end
        else if (coef_we && coef_addr < N_COEFS)
        begin
            bank[coef_addr] <= coef_wdata;
        end
    end

    // A sample waiting through a stall keeps the bank as it was at acceptance
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            held <= 1'b0;
        else if (pipe_en)
            held <= 1'b0;
        else if (sample_vld)
            held <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (sample_vld && !pipe_en && !held)
        begin
            for (int i = 0; i < N_COEFS; i++)
                held_bank[i] <= bank[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe_en)
        begin
            for (int i = 0; i < N_COEFS; i++)
                snap[1][i] <= held ? held_bank[i] : bank[i];
            for (int s = 2; s <= N_STAGES + 1; s++)
                for (int i = s; i < N_COEFS; i++)
                    snap[s][i] <= snap[s - 1][i];
        end
    end

    assign coef_c0 = snap[1][0];
    assign coef_c1 = snap[1][1];

    // Coefficient k leaves from row k, in step with power k
    always_comb
    begin
        for (int k = 0; k < N_STAGES; k++)
            coef_stage[k] = snap[k + 2][k + 2];
    end

endmodule

`default_nettype wire

/* poly_combine.sv */
`timescale 1ns/100ps
`default_nettype none

module poly_combine
(
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                pipe_en,
    input  poly_data_pkg::data_t                                pow_x1,
    input  logic                 [poly_data_pkg::N_STAGES:0]     pow_vld,
    input  poly_data_pkg::data_t [poly_data_pkg::N_STAGES - 1:0] pow_bus,
    input  poly_data_pkg::coef_t                                coef_c0,
    input  poly_data_pkg::coef_t                                coef_c1,
    input  poly_data_pkg::coef_t [poly_data_pkg::N_STAGES - 1:0] coef_stage,
    output logic                                                sum_vld,
    output poly_data_pkg::data_t                                sum_data
);

    import poly_data_pkg::*;

    // Partial sum k covers the terms up to x^k
    data_t                  acc [1:N_STAGES + 1];
    logic  [1:N_STAGES + 1] vld;

    // A partial sum is valid once the sum before it and its own power are
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld <= '0;
        end
        else if (pipe_en)
        begin
            vld[1] <= pow_vld[0];
            for (int k = 2; k <= N_STAGES + 1; k++)
                vld[k] <= vld[k - 1] && pow_vld[k - 1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe_en)
        begin
            acc[1] <= coef_c0 + coef_c1 * pow_x1;
            for (int k = 2; k <= N_STAGES + 1; k++)
                acc[k] <= acc[k - 1] + coef_stage[k - 2] * pow_bus[k - 2];
        end
    end

    assign sum_vld  = vld[N_STAGES + 1];
    assign sum_data = acc[N_STAGES + 1];

endmodule

`default_nettype wire

/* result_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module result_tx
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sum_vld,
    input  poly_data_pkg::data_t sum_data,
    output logic                 out_req,
    input  logic                 out_ack,
    output poly_data_pkg::data_t out_data,
    output logic                 pipe_en
);

    import poly_ctrl_pkg::*;

    tx_state_t state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= TX_IDLE;
        end
        else
        begin
            case (state)
                TX_IDLE:
                    if (sum_vld)
                        state <= TX_REQ;
                TX_REQ:
                    if (out_ack)
                        state <= TX_WAIT_LOW;
                TX_WAIT_LOW:
                    if (!out_ack)
                        state <= TX_IDLE;
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == TX_IDLE && sum_vld)
            out_data <= sum_data;
    end

    assign out_req = (state == TX_REQ);

    // The datapath only moves while no result is held here
    assign pipe_en = (state == TX_IDLE);

endmodule

`default_nettype wire

/* poly_eval_top.sv */
`timescale 1ns/100ps
`default_nettype none

module poly_eval_top
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_req,
    output logic                       in_ack,
    input  poly_data_pkg::data_t       in_data,
    input  logic                       coef_we,
    input  poly_data_pkg::coef_addr_t  coef_addr,
    input  poly_data_pkg::coef_t       coef_wdata,
    output logic                       out_req,
    input  logic                       out_ack,
    output poly_data_pkg::data_t       out_data
);

    import poly_data_pkg::*;

    logic                         pipe_en;
    logic                         sample_vld;
    data_t                        sample_x;
    data_t                        pow_x1;
    logic  [N_STAGES:0]           pow_vld;
    data_t [N_STAGES - 1:0]       pow_bus;
    coef_t                        coef_c0;
    coef_t                        coef_c1;
    coef_t [N_STAGES - 1:0]       coef_stage;
    logic                         sum_vld;
    data_t                        sum_data;

    sample_rx u_rx
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .in_req     ( in_req     ),
        .in_ack     ( in_ack     ),
        .in_data    ( in_data    ),
        .pipe_en    ( pipe_en    ),
        .sample_vld ( sample_vld ),
        .sample_x   ( sample_x   )
    );

    // Powers and coefficients run side by side and meet in the combiner
    pow_pipe u_pow
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pipe_en    ( pipe_en    ),
        .sample_vld ( sample_vld ),
        .sample_x   ( sample_x   ),
        .pow_x1     ( pow_x1     ),
        .pow_vld    ( pow_vld    ),
        .pow_bus    ( pow_bus    )
    );

    coef_pipe u_coef
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pipe_en    ( pipe_en    ),
        .coef_we    ( coef_we    ),
        .coef_addr  ( coef_addr  ),
        .coef_wdata ( coef_wdata ),
        .sample_vld ( sample_vld ),
        .coef_c0    ( coef_c0    ),
        .coef_c1    ( coef_c1    ),
        .coef_stage ( coef_stage )
    );

    poly_combine u_comb
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pipe_en    ( pipe_en    ),
        .pow_x1     ( pow_x1     ),
        .pow_vld    ( pow_vld    ),
        .pow_bus    ( pow_bus    ),
        .coef_c0    ( coef_c0    ),
        .coef_c1    ( coef_c1    ),
        .coef_stage ( coef_stage ),
        .sum_vld    ( sum_vld    ),
        .sum_data   ( sum_data   )
    );

    result_tx u_tx
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sum_vld    ( sum_vld    ),
        .sum_data   ( sum_data   ),
        .out_req    ( out_req    ),
        .out_ack    ( out_ack    ),
        .out_data   ( out_data   ),
        .pipe_en    ( pipe_en    )
    );

endmodule

`default_nettype wire

/* poly_eval_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module poly_eval_properties
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_req,
    input logic                 in_ack,
    input logic                 out_req,
    input logic                 out_ack,
    input poly_data_pkg::data_t out_data
);

    import poly_ctrl_pkg::*;

    // An acknowledge only answers a request that was already up
    assert property (@(posedge clk) disable iff (!rst_n) $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose while in_req was low");

    assert property (@(posedge clk) disable iff (!rst_n)
                     out_req && $past(out_req) |-> $stable(out_data))
        else $error("out_data changed while out_req was high");

    assert property (@(posedge clk) disable iff (!rst_n) out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack");

    assert property (@(posedge clk) !rst_n |-> !in_ack && !out_req)
        else $error("Handshake outputs active during reset");

endmodule

bind poly_eval_top poly_eval_properties u_props (.*);

`default_nettype wire

/* poly_eval_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module poly_eval_tb;

    import poly_data_pkg::*;
    import poly_ctrl_pkg::*;

    localparam int NUM_SAMPLES = 200;
    localparam int TIMEOUT     = 500;

    logic       clk;
    logic       rst_n;
    logic       in_req;
    logic       in_ack;
    data_t      in_data;
    logic       coef_we;
    coef_addr_t coef_addr;
    coef_t      coef_wdata;
    logic       out_req;
    logic       out_ack;
    data_t      out_data;

    // Expected results in acceptance order
    data_t exp_q [$];
    coef_t model_coef [N_COEFS];

    int   cycle;
    int   ack_cycle;
    int   req_cycle;
    int   samples_sent;
    int   results_seen;
    int   error_count;
    int   timeout_count;
    int   seed_init;
    bit   host_done;
    logic out_req_prev;

    poly_eval_top u_dut
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .in_req     ( in_req     ),
        .in_ack     ( in_ack     ),
        .in_data    ( in_data    ),
        .coef_we    ( coef_we    ),
        .coef_addr  ( coef_addr  ),
        .coef_wdata ( coef_wdata ),
        .out_req    ( out_req    ),
        .out_ack    ( out_ack    ),
        .out_data   ( out_data   )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // Every result offered by the DUT counts, whether or not the sink expects it
    always @(posedge clk)
    begin
        out_req_prev <= out_req;
        if (rst_n && out_req && !out_req_prev)
            results_seen++;
    end

    // A write seen here takes effect in the bank at the next rising edge
    always @(negedge clk)
    begin
        if (rst_n && coef_we && coef_addr < N_COEFS)
            model_coef[coef_addr] = coef_wdata;
    end

    function automatic data_t poly_model(input data_t x);
        data_t sum;
        data_t pw;
        sum = '0;
        pw  = 16'd1;
        for (int k = 0; k < N_COEFS; k++)
        begin
            sum = sum + model_coef[k] * pw;
            pw  = pw * x;
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %0d ns %s expected %0h actual %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns while waiting for %s", $time, what);
        timeout_count++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_coef(input int addr, input int value);
        next_cycle();
        coef_we    = 1'b1;
        coef_addr  = addr;
        coef_wdata = value;
        next_cycle();
        coef_we    = 1'b0;
    endtask

    task automatic write_random_coefs();
        int n;
        n = 0;
        while (!host_done && n < NUM_SAMPLES * TIMEOUT)
        begin
            next_cycle();
            coef_we    = ($urandom_range(3, 0) == 0);
            coef_addr  = $urandom_range(7, 0);
            coef_wdata = $urandom;
            n++;
        end
        next_cycle();
        coef_we = 1'b0;
    endtask

    task automatic send_samples(input int count, input int max_gap);
        int    waited;
        data_t x;
        for (int i = 0; i < count; i++)
        begin
            next_cycle();
            repeat ($urandom_range(max_gap, 0))
                next_cycle();
            x       = $urandom;
            in_data = x;
            in_req  = 1'b1;
            waited  = 0;
            while (!in_ack && waited < TIMEOUT)
            begin
                next_cycle();
                waited++;
            end
            if (!in_ack)
            begin
                report_timeout("in_ack to rise");
                in_req = 1'b0;
                return;
            end
            // The sample takes the coefficients present at its capture
            ack_cycle = cycle;
            exp_q.push_back(poly_model(x));
            samples_sent++;
            in_req = 1'b0;
            waited = 0;
            while (in_ack && waited < TIMEOUT)
            begin
                next_cycle();
                waited++;
            end
            if (in_ack)
            begin
                report_timeout("in_ack to fall");
                return;
            end
        end
    endtask

    task automatic receive_results(input int count, input int max_delay);
        int    waited;
        data_t expected;
        for (int i = 0; i < count; i++)
        begin
            next_cycle();
            waited = 0;
            while (!out_req && waited < TIMEOUT)
            begin
                next_cycle();
                waited++;
            end
            if (!out_req)
            begin
                report_timeout("out_req to rise");
                return;
            end
            req_cycle = cycle;
            if (exp_q.size() == 0)
            begin
                $display("A result arrived at %0d ns with no sample pending", $time);
                error_count++;
            end
            else
            begin
                expected = exp_q.pop_front();
                check_value("out_data", expected, out_data);
            end
            repeat ($urandom_range(max_delay, 0))
                next_cycle();
            out_ack = 1'b1;
            waited  = 0;
            while (out_req && waited < TIMEOUT)
            begin
                next_cycle();
                waited++;
            end
            out_ack = 1'b0;
            if (out_req)
            begin
                report_timeout("out_req to fall");
                return;
            end
        end
    endtask

    // A result beyond the accepted samples would raise out_req in this window
    task automatic check_output_idle(input int cycles);
        int waited;
        waited = 0;
        while (!out_req && waited < cycles)
        begin
            next_cycle();
            waited++;
        end
        check_value("out_req", 0, out_req);
    endtask

    initial
    begin
        seed_init     = $urandom(3);
        rst_n         = 1'b0;
        in_req        = 1'b0;
        in_data       = '0;
        coef_we       = 1'b0;
        coef_addr     = '0;
        coef_wdata    = '0;
        out_ack       = 1'b0;
        out_req_prev  = 1'b0;
        cycle         = 0;
        ack_cycle     = 0;
        req_cycle     = 0;
        samples_sent  = 0;
        results_seen  = 0;
        error_count   = 0;
        timeout_count = 0;
        host_done     = 1'b0;
        for (int k = 0; k < N_COEFS; k++)
            model_coef[k] = '0;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("in_ack", 0, in_ack);
        check_value("out_req", 0, out_req);

        // All coefficients are still zero, so this result must be zero
        fork
            send_samples(1, 0);
            receive_results(1, 0);
        join

        fork
            begin
                send_samples(NUM_SAMPLES, 3);
                host_done = 1'b1;
            end
            receive_results(NUM_SAMPLES, 5);
            write_random_coefs();
        join

        for (int k = 0; k < N_COEFS; k++)
            write_coef(k, $urandom);
        write_coef(6, 16'hffff);
        write_coef(7, 16'hffff);
        repeat (4) next_cycle();

        // Single sample through an idle output measures the latency
        fork
            send_samples(1, 0);
            receive_results(1, 0);
        join
        check_value("latency", LATENCY, req_cycle - ack_cycle);
        check_output_idle(2 * LATENCY);
        check_value("result_count", samples_sent, results_seen);
        check_value("pending_results", 0, exp_q.size());

        $display("errors %0d timeouts %0d samples %0d results %0d",
                 error_count, timeout_count, samples_sent, results_seen);
        if (error_count == 0 && timeout_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* poly_eval_top.f */
poly_data_pkg.sv
poly_ctrl_pkg.sv
sample_rx.sv
pow_pipe.sv
coef_pipe.sv
poly_combine.sv
result_tx.sv
poly_eval_top.sv
poly_eval_properties.sv
poly_eval_tb.sv
